//--- common/iobuf_consts.svh
`ifndef IOBUF_CONSTS_SVH
`define IOBUF_CONSTS_SVH

// Buffer geometry
`define IOBUF_DATA_WIDTH 32
`define IOBUF_ADDR_WIDTH 6
`define IOBUF_DEPTH 64

// Nested loop levels per address generator
`define IOBUF_LEVELS 4

// Instruction format
`define IOBUF_OPCODE_WIDTH 3
`define IOBUF_INSTR_WIDTH 25

// Port numbers carried in REP and DSU payloads
`define IOBUF_WRITE_PORT 2
`define IOBUF_READ_PORT 3

`endif

//--- common/agu_pkg.sv
`include "iobuf_consts.svh"

package agu_pkg;

  typedef logic [`IOBUF_ADDR_WIDTH-1:0] agu_addr_t;

  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    DELAY,
    COUNT
  } level_state_e;

endpackage

//--- common/iobuf_isa_pkg.sv
`include "iobuf_consts.svh"

package iobuf_isa_pkg;

  typedef enum logic [`IOBUF_OPCODE_WIDTH-1:0] {
    REP  = 3'd0,
    REPX = 3'd1,
    DSU  = 3'd6
  } opcode_e;

  // Everything below the opcode
  typedef logic [`IOBUF_INSTR_WIDTH-`IOBUF_OPCODE_WIDTH-1:0] payload_t;

  // Loop level configuration
  typedef struct packed {
    logic [1:0] port;
    logic [1:0] level;
    logic [5:0] iter;
    logic [5:0] step;
    logic [5:0] delay;
  } rep_t;

  // Start address of a port
  typedef struct packed {
    logic [1:0]  port;
    logic [5:0]  init_addr;
    logic [13:0] unused;
  } dsu_t;

endpackage

//--- common/agu_cfg_if.sv
`include "iobuf_consts.svh"

interface agu_cfg_if
  import agu_pkg::*;
();

  logic                              load_initial;
  agu_addr_t                         init_addr;
  logic                              load_level;
  logic [$clog2(`IOBUF_LEVELS)-1:0]  level;
  agu_addr_t                         iter;
  agu_addr_t                         step;
  agu_addr_t                         delay;

  modport decoder (
    output load_initial, init_addr, load_level, level, iter, step, delay
  );

  modport agu (
    input load_initial, init_addr, load_level, level, iter, step, delay
  );

endinterface

//--- logic/instr_decoder.sv
`include "iobuf_consts.svh"

module instr_decoder
  import iobuf_isa_pkg::*;
(
  input  logic                          instr_en,
  input  logic [`IOBUF_INSTR_WIDTH-1:0] instr,
  agu_cfg_if.decoder                    wr_cfg,
  agu_cfg_if.decoder                    rd_cfg
);

  opcode_e  opcode;
  payload_t payload;
  rep_t     rep;
  dsu_t     dsu;
  logic     rep_valid;
  logic     dsu_valid;

  assign opcode  = opcode_e'(instr[`IOBUF_INSTR_WIDTH-1 -: `IOBUF_OPCODE_WIDTH]);
  assign payload = instr[`IOBUF_INSTR_WIDTH-`IOBUF_OPCODE_WIDTH-1:0];
  assign rep     = rep_t'(payload);
  assign dsu     = dsu_t'(payload);

  // REPX and unknown opcodes fall through
  assign rep_valid = instr_en && (opcode == REP);
  assign dsu_valid = instr_en && (opcode == DSU);

  // Strobes per port
  assign wr_cfg.load_level   = rep_valid && (rep.port == 2'(`IOBUF_WRITE_PORT));
  assign wr_cfg.load_initial = dsu_valid && (dsu.port == 2'(`IOBUF_WRITE_PORT));
  assign rd_cfg.load_level   = rep_valid && (rep.port == 2'(`IOBUF_READ_PORT));
  assign rd_cfg.load_initial = dsu_valid && (dsu.port == 2'(`IOBUF_READ_PORT));

  // Fields go to both sides, only the strobe selects
  assign wr_cfg.init_addr = dsu.init_addr;
  assign wr_cfg.level     = rep.level;
  assign wr_cfg.iter      = rep.iter;
  assign wr_cfg.step      = rep.step;
  assign wr_cfg.delay     = rep.delay;

  assign rd_cfg.init_addr = dsu.init_addr;
  assign rd_cfg.level     = rep.level;
  assign rd_cfg.iter      = rep.iter;
  assign rd_cfg.step      = rep.step;
  assign rd_cfg.delay     = rep.delay;

endmodule

//--- agu/agu_level.sv
`include "iobuf_consts.svh"

module agu_level
  import agu_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      activate,
  input  logic      load,
  input  agu_addr_t iter,
  input  agu_addr_t step,
  input  agu_addr_t delay,
  input  logic      lower_finish,
  input  logic      higher_finish,
  input  logic      higher_restart,
  output logic      counting,
  output logic      finish,
  output logic      lower_restart,
  output agu_addr_t addr
);

  level_state_e state;
  level_state_e state_next;
  agu_addr_t    iter_q;
  agu_addr_t    step_q;
  agu_addr_t    delay_q;
  agu_addr_t    iter_cnt;
  agu_addr_t    iter_cnt_next;
  agu_addr_t    delay_cnt;
  agu_addr_t    delay_cnt_next;
  agu_addr_t    addr_next;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      iter_q  <= '0;
      step_q  <= '0;
      delay_q <= '0;
    end else if (load) begin
      iter_q  <= iter;
      step_q  <= step;
      delay_q <= delay;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      addr      <= '0;
      iter_cnt  <= '0;
      delay_cnt <= '0;
    end else begin
      state     <= state_next;
      addr      <= addr_next;
      iter_cnt  <= iter_cnt_next;
      delay_cnt <= delay_cnt_next;
    end
  end

  // Last step taken and everything below is done
  assign finish   = lower_finish && (iter_cnt == iter_q);
  assign counting = (state == COUNT);

  always_comb begin
    state_next     = state;
    addr_next      = addr;
    iter_cnt_next  = iter_cnt;
    delay_cnt_next = delay_cnt;
    lower_restart  = 1'b0;

    case (state)
      IDLE: begin
        addr_next      = '0;
        iter_cnt_next  = '0;
        delay_cnt_next = '0;
        if (activate) begin
          state_next = COUNT;
        end
      end

      COUNT, WAIT: begin
        if (!lower_finish) begin
          state_next     = WAIT;
          delay_cnt_next = '0;
        end else if (finish && higher_finish) begin
          // Whole nest done
          state_next    = IDLE;
          addr_next     = '0;
          iter_cnt_next = '0;
        end else if (finish) begin
          // Wrap once the level above steps
          if (higher_restart) begin
            state_next    = COUNT;
            addr_next     = '0;
            iter_cnt_next = '0;
            lower_restart = 1'b1;
          end else begin
            state_next = WAIT;
          end
        end else if (delay_q != '0) begin
          state_next = DELAY;
        end else begin
          state_next    = COUNT;
          addr_next     = addr + step_q;
          iter_cnt_next = iter_cnt + 1'b1;
          lower_restart = 1'b1;
        end
      end

      DELAY: begin
        delay_cnt_next = delay_cnt + 1'b1;
        if (agu_addr_t'(delay_cnt + 1'b1) == delay_q) begin
          state_next     = COUNT;
          addr_next      = addr + step_q;
          iter_cnt_next  = iter_cnt + 1'b1;
          delay_cnt_next = '0;
          lower_restart  = 1'b1;
        end
      end

      default: begin
        state_next = IDLE;
      end
    endcase
  end

endmodule

//--- agu/agu.sv
`include "iobuf_consts.svh"

module agu
  import agu_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      activate,
  agu_cfg_if.agu    cfg,
  output logic      addr_valid,
  output agu_addr_t addr
);

  localparam int LEVELS = `IOBUF_LEVELS;

  agu_addr_t             init_addr_q;
  agu_addr_t             base_addr;
  logic [LEVELS-1:0]     level_load;
  logic [LEVELS-1:0]     counting;
  logic [LEVELS:0]       finish;
  logic [LEVELS:0]       restart;
  agu_addr_t             level_addr [LEVELS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      init_addr_q <= '0;
      base_addr   <= '0;
    end else begin
      if (cfg.load_initial) begin
        init_addr_q <= cfg.init_addr;
      end
      if (activate) begin
        base_addr <= init_addr_q;
      end
    end
  end

  always_comb begin
    level_load = '0;
    if (cfg.load_level) begin
      level_load[cfg.level] = 1'b1;
    end
  end

  // Chain ends count as always done
  assign finish[0]       = 1'b1;
  assign restart[LEVELS] = 1'b1;

  // Top finish means every level sits on its last step
  for (genvar i = 0; i < LEVELS; i++) begin : g_level
    agu_level i_agu_level (
      .clk            (clk),
      .rst_n          (rst_n),
      .activate       (activate),
      .load           (level_load[i]),
      .iter           (cfg.iter),
      .step           (cfg.step),
      .delay          (cfg.delay),
      .lower_finish   (finish[i]),
      .higher_finish  (finish[LEVELS]),
      .higher_restart (restart[i+1]),
      .counting       (counting[i]),
      .finish         (finish[i+1]),
      .lower_restart  (restart[i]),
      .addr           (level_addr[i])
    );
  end

  // Sum wraps at the buffer depth
  always_comb begin
    addr = base_addr;
    for (int i = 0; i < LEVELS; i++) begin
      addr = addr + level_addr[i];
    end
  end

  assign addr_valid = |counting;

endmodule

//--- logic/sram_buffer.sv
`include "iobuf_consts.svh"

module sram_buffer
  import agu_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         wr_en,
  input  agu_addr_t                    wr_addr,
  input  logic [`IOBUF_DATA_WIDTH-1:0] wr_data,
  input  logic                         rd_en,
  input  agu_addr_t                    rd_addr,
  output logic [`IOBUF_DATA_WIDTH-1:0] rd_data,
  output logic                         rd_valid
);

  logic [`IOBUF_DATA_WIDTH-1:0] mem [`IOBUF_DEPTH];
  logic [`IOBUF_DATA_WIDTH-1:0] rd_word;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    // Same-address read sees the old word
    if (rd_en) begin
      rd_word <= mem[rd_addr];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en;
    end
  end

  assign rd_data = rd_valid ? rd_word : '0;

endmodule

//--- logic/iobuf_top.sv
`include "iobuf_consts.svh"

module iobuf_top
  import agu_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          instr_en,
  input  logic [`IOBUF_INSTR_WIDTH-1:0] instr,
  input  logic                          activate_write,
  input  logic                          activate_read,
  input  logic [`IOBUF_DATA_WIDTH-1:0]  data_in,
  output logic [`IOBUF_DATA_WIDTH-1:0]  data_out,
  output logic                          data_out_valid
);

  logic      wr_addr_valid;
  agu_addr_t wr_addr;
  logic      rd_addr_valid;
  agu_addr_t rd_addr;

  agu_cfg_if wr_cfg ();
  agu_cfg_if rd_cfg ();

  instr_decoder i_instr_decoder (
    .instr_en (instr_en),
    .instr    (instr),
    .wr_cfg   (wr_cfg.decoder),
    .rd_cfg   (rd_cfg.decoder)
  );

  // Write side
  agu i_wr_agu (
    .clk        (clk),
    .rst_n      (rst_n),
    .activate   (activate_write),
    .cfg        (wr_cfg.agu),
    .addr_valid (wr_addr_valid),
    .addr       (wr_addr)
  );

  // Read side
  agu i_rd_agu (
    .clk        (clk),
    .rst_n      (rst_n),
    .activate   (activate_read),
    .cfg        (rd_cfg.agu),
    .addr_valid (rd_addr_valid),
    .addr       (rd_addr)
  );

  sram_buffer i_sram_buffer (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_en    (wr_addr_valid),
    .wr_addr  (wr_addr),
    .wr_data  (data_in),
    .rd_en    (rd_addr_valid),
    .rd_addr  (rd_addr),
    .rd_data  (data_out),
    .rd_valid (data_out_valid)
  );

endmodule

//--- test/iobuf_checker.sv
`include "iobuf_consts.svh"

module iobuf_checker (
  input logic                         clk,
  input logic                         rst_n,
  input logic [`IOBUF_DATA_WIDTH-1:0] data_out,
  input logic                         data_out_valid,
  input logic                         rd_addr_valid,
  input logic                         wr_addr_valid
);

  timeunit 1ns;
  timeprecision 1ps;

  // Read data gated off between beats
  a_data_gated: assert property (
    @(posedge clk) disable iff (!rst_n) !data_out_valid |-> (data_out == '0)
  ) else $error("data_out is nonzero while data_out_valid is low");

  // One cycle of read latency
  a_valid_after_addr: assert property (
    @(posedge clk) disable iff (!rst_n) data_out_valid |-> $past(rd_addr_valid)
  ) else $error("data_out_valid without a read address in the cycle before");

  a_quiet_in_reset: assert property (
    @(posedge clk) (!rst_n && !$past(rst_n)) |->
      !(data_out_valid || rd_addr_valid || wr_addr_valid)
  ) else $error("a valid signal is high during reset");

endmodule

bind iobuf_top iobuf_checker i_iobuf_checker (
  .clk            (clk),
  .rst_n          (rst_n),
  .data_out       (data_out),
  .data_out_valid (data_out_valid),
  .rd_addr_valid  (rd_addr_valid),
  .wr_addr_valid  (wr_addr_valid)
);

//--- test/tb_iobuf.sv
`include "iobuf_consts.svh"

module tb_iobuf
  import iobuf_isa_pkg::*;
  import agu_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  typedef logic [`IOBUF_DATA_WIDTH-1:0] word_t;

  // Each test may take a full buffer of slow beats plus setup
  localparam int TIMEOUT_CYCLES = 6 * (`IOBUF_DEPTH * 8 + 100);

  logic                          clk;
  logic                          rst_n;
  logic                          instr_en;
  logic [`IOBUF_INSTR_WIDTH-1:0] instr;
  logic                          activate_write;
  logic                          activate_read;
  word_t                         data_in;
  word_t                         data_out;
  logic                          data_out_valid;

  logic [31:0] lcg_state = 32'h289f34a5;
  int          cycles = 0;
  int          checks = 0;
  int          errors = 0;
  int          errors_at_start = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  // Model side 0 is the write AGU, side 1 the read AGU
  int          cfg_init [2];
  int          cfg_iter [2][`IOBUF_LEVELS];
  int          cfg_step [2][`IOBUF_LEVELS];
  int          cfg_delay [2][`IOBUF_LEVELS];
  word_t       model_mem [`IOBUF_DEPTH];
  agu_addr_t   exp_addr [$];

  iobuf_top i_iobuf_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_en       (instr_en),
    .instr          (instr),
    .activate_write (activate_write),
    .activate_read  (activate_read),
    .data_in        (data_in),
    .data_out       (data_out),
    .data_out_valid (data_out_valid)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    logic [31:0] r;
    r = next_rand();
    return lo + int'((r >> 8) % 32'(hi - lo + 1));
  endfunction

  // Opcode on top, then port, level, iter, step, delay
  function automatic logic [`IOBUF_INSTR_WIDTH-1:0] rep_instr(
    input opcode_e op, input int port, input int level, input int iter,
    input int step, input int delay);
    return {op, 2'(port), 2'(level), 6'(iter), 6'(step), 6'(delay)};
  endfunction

  function automatic logic [`IOBUF_INSTR_WIDTH-1:0] dsu_instr(input int port, input int init);
    return {DSU, 2'(port), 6'(init), 14'd0};
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL at %0t: %s expected %0h, got %0h", $time, name, exp, act);
    end
  endtask

  task automatic send_instr(input logic en, input logic [`IOBUF_INSTR_WIDTH-1:0] word);
    @(posedge clk);
    instr_en <= en;
    instr    <= word;
  endtask

  function automatic void clear_cfg(input int side);
    cfg_init[side] = 0;
    for (int l = 0; l < `IOBUF_LEVELS; l++) begin
      cfg_iter[side][l]  = 0;
      cfg_step[side][l]  = 0;
      cfg_delay[side][l] = 0;
    end
  endfunction

  function automatic void set_linear(input int side, input int init, input int iter);
    clear_cfg(side);
    cfg_init[side]    = init;
    cfg_iter[side][0] = iter;
    cfg_step[side][0] = 1;
  endfunction

  // All levels are rewritten so no stale config survives
  task automatic program_agu(input int side);
    int port;
    port = (side == 1) ? `IOBUF_READ_PORT : `IOBUF_WRITE_PORT;
    send_instr(1'b1, dsu_instr(port, cfg_init[side]));
    for (int l = 0; l < `IOBUF_LEVELS; l++) begin
      send_instr(1'b1, rep_instr(REP, port, l, cfg_iter[side][l], cfg_step[side][l],
                                 cfg_delay[side][l]));
    end
    @(posedge clk);
    instr_en <= 1'b0;
  endtask

  function automatic void build_addrs(input int side);
    int total;
    int rem;
    int sum;
    exp_addr.delete();
    total = 1;
    for (int l = 0; l < `IOBUF_LEVELS; l++) begin
      total = total * (cfg_iter[side][l] + 1);
    end
    for (int idx = 0; idx < total; idx++) begin
      rem = idx;
      sum = cfg_init[side];
      // Level 0 innermost
      for (int l = 0; l < `IOBUF_LEVELS; l++) begin
        sum = sum + (rem % (cfg_iter[side][l] + 1)) * cfg_step[side][l];
        rem = rem / (cfg_iter[side][l] + 1);
      end
      exp_addr.push_back(agu_addr_t'(sum % `IOBUF_DEPTH));
    end
  endfunction

  // Zero delay, so one word per cycle right after activate
  task automatic run_write();
    word_t word;
    build_addrs(0);
    @(posedge clk);
    activate_write <= 1'b1;
    foreach (exp_addr[k]) begin
      @(posedge clk);
      activate_write <= 1'b0;
      word = word_t'(next_rand());
      data_in <= word;
      model_mem[exp_addr[k]] = word;
    end
    // Junk that must not land in the buffer
    @(posedge clk);
    data_in <= word_t'(next_rand());
    repeat (3) @(posedge clk);
  endtask

  task automatic run_read(input string name, input bit contiguous);
    int got;
    int first_cyc;
    int last_cyc;
    int extra;
    build_addrs(1);
    got = 0;
    first_cyc = 0;
    last_cyc = 0;
    extra = 0;
    @(posedge clk);
    activate_read <= 1'b1;
    @(posedge clk);
    activate_read <= 1'b0;
    while (got < exp_addr.size()) begin
      @(negedge clk);
      if (data_out_valid) begin
        if (got == 0) begin
          first_cyc = cycles;
        end
        last_cyc = cycles;
        check({name, " data_out"}, 64'(model_mem[exp_addr[got]]), 64'(data_out));
        got++;
      end else begin
        check({name, " data_out between beats"}, 64'd0, 64'(data_out));
      end
    end
    repeat (20) begin
      @(negedge clk);
      if (data_out_valid) begin
        extra++;
      end
    end
    check({name, " data_out_valid beats after end"}, 64'd0, 64'(extra));
    if (contiguous) begin
      check({name, " data_out_valid span"}, 64'(exp_addr.size()),
            64'(last_cyc - first_cyc + 1));
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  initial begin
    int start;
    int len;
    clk = 1'b0;
    rst_n = 1'b0;
    instr_en = 1'b0;
    instr = '0;
    activate_write = 1'b0;
    activate_read = 1'b0;
    data_in = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    repeat (10) begin
      @(negedge clk);
      check("data_out_valid", 64'd0, 64'(data_out_valid));
      check("data_out", 64'd0, 64'(data_out));
    end
    report_test("reset");

    start = rand_range(0, `IOBUF_DEPTH - 1);
    len = rand_range(1, `IOBUF_DEPTH);
    set_linear(0, start, len - 1);
    program_agu(0);
    set_linear(1, start, len - 1);
    program_agu(1);
    run_write();
    run_read("linear", 1'b1);
    report_test("linear write then read");

    // Fill everything first so the full read is defined
    set_linear(0, 0, `IOBUF_DEPTH - 1);
    program_agu(0);
    run_write();
    clear_cfg(0);
    cfg_init[0] = rand_range(0, `IOBUF_DEPTH - 1);
    for (int l = 0; l < 2; l++) begin
      cfg_iter[0][l] = rand_range(0, 7);
      cfg_step[0][l] = rand_range(0, `IOBUF_DEPTH - 1);
    end
    program_agu(0);
    run_write();
    set_linear(1, 0, `IOBUF_DEPTH - 1);
    program_agu(1);
    run_read("strides", 1'b1);
    report_test("multi-level strides");

    clear_cfg(1);
    cfg_init[1] = rand_range(0, `IOBUF_DEPTH - 1);
    // Three levels of up to four steps fit in one buffer
    for (int l = 0; l < 3; l++) begin
      cfg_iter[1][l]  = rand_range(1, 3);
      cfg_step[1][l]  = rand_range(0, `IOBUF_DEPTH - 1);
      cfg_delay[1][l] = rand_range(1, 7);
    end
    program_agu(1);
    run_read("delays", 1'b0);
    report_test("delays on read");

    send_instr(1'b0, rep_instr(REP, `IOBUF_READ_PORT, 0, 5, rand_range(1, 63), 0));
    send_instr(1'b1, rep_instr(REPX, `IOBUF_READ_PORT, 0, 3, rand_range(1, 63), 0));
    send_instr(1'b1, rep_instr(REPX, `IOBUF_READ_PORT, 1, 2, rand_range(1, 63), 2));
    send_instr(1'b1, rep_instr(REP, 0, 0, 6, rand_range(1, 63), 0));
    send_instr(1'b1, rep_instr(REP, 1, 1, 4, rand_range(1, 63), 1));
    send_instr(1'b1, dsu_instr(1, rand_range(0, 63)));
    send_instr(1'b0, dsu_instr(`IOBUF_READ_PORT, rand_range(0, 63)));
    @(posedge clk);
    instr_en <= 1'b0;
    run_read("ignored", 1'b0);
    report_test("ignored instructions");

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+common
common/agu_pkg.sv
common/iobuf_isa_pkg.sv
common/agu_cfg_if.sv
logic/instr_decoder.sv
agu/agu_level.sv
agu/agu.sv
logic/sram_buffer.sv
logic/iobuf_top.sv
test/iobuf_checker.sv
test/tb_iobuf.sv

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  -f src.f --top-module tb_iobuf -o sim_iobuf \
  && ./obj_dir/sim_iobuf | tee /dev/stderr | grep -qx '>>> PASS' \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
